/* hw/i2c_pkg.sv */
package i2c_pkg;

        // 50 MHz system clock into a 400 kHz SCL
        localparam integer c_sys_clock_hz = 50_000_000;
        localparam integer c_scl_hz       = 400_000;
        localparam integer c_quarter_max  = c_sys_clock_hz / c_scl_hz / 4 - 1; // 30
        localparam integer c_div_w        = $clog2(c_quarter_max + 1);

        localparam integer c_cmd_w  = 6;
        localparam integer c_data_w = 8;

        // bit positions in the one-hot command word
        typedef enum logic [2:0]
        {
                cmd_wr   = 3'd0,
                cmd_sta  = 3'd1,
                cmd_rd   = 3'd2,
                cmd_sto  = 3'd3,
                cmd_ack  = 3'd4,
                cmd_nack = 3'd5
        } cmd_bit_e;

        typedef enum logic [2:0]
        {
                st_idle       = 3'd0,
                st_start      = 3'd1,
                st_write      = 3'd2,
                st_read       = 3'd3,
                st_slave_ack  = 3'd4,
                st_master_ack = 3'd5,
                st_stop       = 3'd6
        } state_e;

        typedef enum logic [1:0]
        {
                ph_start   = 2'd0,
                ph_bit_out = 2'd1,
                ph_bit_in  = 2'd2,
                ph_stop    = 2'd3
        } phase_e;

endpackage

/* hw/i2c_phase_if.sv */
`timescale 1ns/1ns

interface i2c_phase_if;

        logic                   phase_go;       // one cycle while engine idle
        i2c_pkg::phase_e        phase_kind;
        logic                   phase_sda;      // level for ph_bit_out
        logic                   phase_done;
        logic                   phase_bit;      // valid with phase_done

        modport fsm
        (
                output  phase_go,
                output  phase_kind,
                output  phase_sda,
                input   phase_done,
                input   phase_bit
        );

        modport engine
        (
                input   phase_go,
                input   phase_kind,
                input   phase_sda,
                output  phase_done,
                output  phase_bit
        );

endinterface

/* hw/i2c_bit_engine.sv */
`timescale 1ns/1ns

module i2c_bit_engine
(
        input   logic                   i_sysclk,
        input   logic                   i_sysrst_n,
        i2c_phase_if.engine             phase,
        input   logic                   i_sda,
        output  logic                   o_iic_scl,
        output  logic                   o_sda_drive_low
);

        logic   [i2c_pkg::c_div_w-1:0]  div_cnt;
        logic   [1:0]                   quarter;
        logic                           busy;
        logic                           active;
        logic                           qtr_end;
        logic                           step;
        logic   [1:0]                   step_q;
        i2c_pkg::phase_e                step_kind;
        i2c_pkg::phase_e                kind_q;
        logic                           bit_q;
        logic                           scl_nxt;
        logic                           low_nxt;

        assign active  = phase.phase_go | busy;
        assign qtr_end = div_cnt == i2c_pkg::c_div_w'(i2c_pkg::c_quarter_max);

        assign phase.phase_done = busy && qtr_end && (quarter == 2'd3);
        assign phase.phase_bit  = bit_q;

        // a new quarter begins on the go cycle or a wrap inside the phase
        assign step      = phase.phase_go | (busy && qtr_end && (quarter != 2'd3));
        assign step_q    = phase.phase_go ? 2'd0 : quarter + 2'd1;
        assign step_kind = phase.phase_go ? phase.phase_kind : kind_q;

        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                begin
                        div_cnt <= '0;
                        quarter <= 2'd0;
                        busy    <= 1'b0;
                end
                else
                begin
                        if (active)
                                div_cnt <= qtr_end ? '0 : div_cnt + 1'b1;
                        if (active && qtr_end)
                                quarter <= quarter + 2'd1;    // wraps to 0 at phase end
                        if (phase.phase_go)
                                busy <= 1'b1;
                        else if (phase.phase_done)
                                busy <= 1'b0;
                end
        end

        always_ff @(posedge i_sysclk)
        begin
                if (phase.phase_go)
                        kind_q <= phase.phase_kind;
                if (busy && qtr_end && (quarter == 2'd2))
                        bit_q <= i_sda;         // end of scl high time
        end

        // line levels for the quarter being entered
        always_comb
        begin
                scl_nxt = o_iic_scl;
                low_nxt = o_sda_drive_low;
                case (step_kind)
                        i2c_pkg::ph_start:
                                case (step_q)
                                        2'd0:
                                        begin
                                                low_nxt = 1'b0;
                                                scl_nxt = 1'b1;
                                        end
                                        2'd1:   scl_nxt = 1'b1;
                                        2'd2:   low_nxt = 1'b1;         // sda falls while scl high
                                        default: scl_nxt = 1'b0;
                                endcase
                        i2c_pkg::ph_stop:
                                case (step_q)
                                        2'd0:
                                        begin
                                                low_nxt = 1'b1;
                                                scl_nxt = 1'b0;
                                        end
                                        2'd1:   scl_nxt = 1'b1;
                                        2'd2:   low_nxt = 1'b0;         // sda rises while scl high
                                        default: scl_nxt = 1'b1;
                                endcase
                        default:
                                case (step_q)
                                        2'd0:
                                        begin
                                                scl_nxt = 1'b0;
                                                low_nxt = (step_kind == i2c_pkg::ph_bit_out) &&
                                                          !phase.phase_sda;
                                        end
                                        2'd1,
                                        2'd2:   scl_nxt = 1'b1;
                                        default: scl_nxt = 1'b0;
                                endcase
                endcase
        end

        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                begin
                        o_iic_scl       <= 1'b1;
                        o_sda_drive_low <= 1'b0;
                end
                else if (step)
                begin
                        o_iic_scl       <= scl_nxt;
                        o_sda_drive_low <= low_nxt;
                end
        end

        a_go_while_busy: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                phase.phase_go |-> !busy);

        a_div_bound: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                div_cnt <= i2c_pkg::c_div_w'(i2c_pkg::c_quarter_max));

endmodule

/* hw/i2c_cmd_fsm.sv */
`timescale 1ns/1ns

module i2c_cmd_fsm
(
        input   logic                           i_sysclk,
        input   logic                           i_sysrst_n,
        input   logic   [i2c_pkg::c_cmd_w-1:0]  i_cmd,
        input   logic   [i2c_pkg::c_data_w-1:0] i_tx_data,
        input   logic                           i_iic_start,
        i2c_phase_if.fsm                        phase,
        output  logic                           o_ack,
        output  logic   [i2c_pkg::c_data_w-1:0] o_rx_data,
        output  logic                           o_iic_done
);

        i2c_pkg::state_e                        state;
        i2c_pkg::state_e                        nxt_state;
        logic   [2:0]                           bit_cnt;
        logic   [i2c_pkg::c_cmd_w-1:0]          cmd_q;
        logic   [i2c_pkg::c_data_w-1:0]         tx_shift;
        logic   [i2c_pkg::c_data_w-1:0]         rx_shift;
        logic                                   accept;
        logic                                   launch;
        logic                                   finish;
        logic                                   last_bit;
        logic                                   go_q;

        // start is ignored unless the command moves the bus
        assign accept = (state == i2c_pkg::st_idle) && i_iic_start &&
                        (i_cmd[i2c_pkg::cmd_sta] | i_cmd[i2c_pkg::cmd_wr] |
                         i_cmd[i2c_pkg::cmd_rd]);

        assign last_bit = bit_cnt == 3'd7;

        always_comb
        begin
                nxt_state = state;
                launch    = 1'b0;
                finish    = 1'b0;
                case (state)
                        i2c_pkg::st_idle:
                                if (accept)
                                begin
                                        launch = 1'b1;
                                        if (i_cmd[i2c_pkg::cmd_sta])
                                                nxt_state = i2c_pkg::st_start;
                                        else if (i_cmd[i2c_pkg::cmd_wr])
                                                nxt_state = i2c_pkg::st_write;
                                        else
                                                nxt_state = i2c_pkg::st_read;
                                end
                        i2c_pkg::st_start:
                                if (phase.phase_done)
                                begin
                                        launch    = 1'b1;
                                        nxt_state = cmd_q[i2c_pkg::cmd_wr] ? i2c_pkg::st_write
                                                                           : i2c_pkg::st_read;
                                end
                        i2c_pkg::st_write:
                                if (phase.phase_done)
                                begin
                                        launch    = 1'b1;
                                        nxt_state = last_bit ? i2c_pkg::st_slave_ack
                                                             : i2c_pkg::st_write;
                                end
                        i2c_pkg::st_read:
                                if (phase.phase_done)
                                begin
                                        launch    = 1'b1;
                                        nxt_state = last_bit ? i2c_pkg::st_master_ack
                                                             : i2c_pkg::st_read;
                                end
                        i2c_pkg::st_slave_ack,
                        i2c_pkg::st_master_ack:
                                if (phase.phase_done)
                                begin
                                        if (cmd_q[i2c_pkg::cmd_sto])
                                        begin
                                                launch    = 1'b1;
                                                nxt_state = i2c_pkg::st_stop;
                                        end
                                        else
                                        begin
                                                finish    = 1'b1;
                                                nxt_state = i2c_pkg::st_idle;
                                        end
                                end
                        default:        // st_stop
                                if (phase.phase_done)
                                begin
                                        finish    = 1'b1;
                                        nxt_state = i2c_pkg::st_idle;
                                end
                endcase
        end

        // kind and level follow the state and are stable on the go cycle
        always_comb
        begin
                case (state)
                        i2c_pkg::st_start:      phase.phase_kind = i2c_pkg::ph_start;
                        i2c_pkg::st_write,
                        i2c_pkg::st_master_ack: phase.phase_kind = i2c_pkg::ph_bit_out;
                        i2c_pkg::st_stop:       phase.phase_kind = i2c_pkg::ph_stop;
                        default:                phase.phase_kind = i2c_pkg::ph_bit_in;
                endcase
        end

        assign phase.phase_sda = (state == i2c_pkg::st_master_ack) ?
                                 (cmd_q[i2c_pkg::cmd_nack] | ~cmd_q[i2c_pkg::cmd_ack]) :
                                 tx_shift[i2c_pkg::c_data_w-1];       // msb first

        assign phase.phase_go = go_q;

        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                begin
                        state      <= i2c_pkg::st_idle;
                        go_q       <= 1'b0;
                        o_iic_done <= 1'b0;
                        bit_cnt    <= 3'd0;
                        o_ack      <= 1'b0;
                        o_rx_data  <= '0;
                end
                else
                begin
                        state      <= nxt_state;
                        go_q       <= launch;
                        o_iic_done <= finish;
                        if (phase.phase_done && ((state == i2c_pkg::st_write) ||
                                                 (state == i2c_pkg::st_read)))
                                bit_cnt <= bit_cnt + 3'd1;      // back to 0 after 8 bits
                        if (phase.phase_done && (state == i2c_pkg::st_slave_ack))
                                o_ack <= phase.phase_bit;       // high means nack
                        if (phase.phase_done && (state == i2c_pkg::st_read) && last_bit)
                                o_rx_data <= {rx_shift[i2c_pkg::c_data_w-2:0], phase.phase_bit};
                end
        end

        always_ff @(posedge i_sysclk)
        begin
                if (accept)
                begin
                        cmd_q    <= i_cmd;
                        tx_shift <= i_tx_data;
                end
                else if (phase.phase_done && (state == i2c_pkg::st_write))
                        tx_shift <= {tx_shift[i2c_pkg::c_data_w-2:0], 1'b0};
                if (phase.phase_done && (state == i2c_pkg::st_read))
                        rx_shift <= {rx_shift[i2c_pkg::c_data_w-2:0], phase.phase_bit};
        end

        a_done_pulse: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                o_iic_done |=> !o_iic_done);

        a_state_legal: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                state inside {i2c_pkg::st_idle, i2c_pkg::st_start, i2c_pkg::st_write,
                              i2c_pkg::st_read, i2c_pkg::st_slave_ack,
                              i2c_pkg::st_master_ack, i2c_pkg::st_stop});

endmodule

/* hw/i2c_word_master.sv */
`timescale 1ns/1ns

module i2c_word_master
(
        input   logic                           i_sysclk,
        input   logic                           i_sysrst_n,
        input   logic   [i2c_pkg::c_cmd_w-1:0]  i_cmd,
        input   logic   [i2c_pkg::c_data_w-1:0] i_tx_data,
        input   logic                           i_iic_start,
        input   logic                           i_sda,          // sampled bus level
        output  logic                           o_iic_scl,
        output  logic                           o_sda_drive_low,
        output  logic                           o_ack,
        output  logic   [i2c_pkg::c_data_w-1:0] o_rx_data,
        output  logic                           o_iic_done
);

        // one phase request and its result
        i2c_phase_if phase_bus ();

        i2c_cmd_fsm u_cmd_fsm
        (
                .i_sysclk       (i_sysclk),
                .i_sysrst_n     (i_sysrst_n),
                .i_cmd          (i_cmd),
                .i_tx_data      (i_tx_data),
                .i_iic_start    (i_iic_start),
                .phase          (phase_bus.fsm),
                .o_ack          (o_ack),
                .o_rx_data      (o_rx_data),
                .o_iic_done     (o_iic_done)
        );

        i2c_bit_engine u_bit_engine
        (
                .i_sysclk               (i_sysclk),
                .i_sysrst_n             (i_sysrst_n),
                .phase                  (phase_bus.engine),
                .i_sda                  (i_sda),
                .o_iic_scl              (o_iic_scl),
                .o_sda_drive_low        (o_sda_drive_low)
        );

endmodule

/* verification/i2c_slave_model.sv */
`timescale 1ns/1ns

module i2c_slave_model
(
        input   logic           i_sysclk,
        input   logic           i_sysrst_n,
        input   logic           i_clear,
        input   logic           i_scl,
        input   logic           i_sda,
        input   logic           i_read,         // put i_rd_byte on the bus
        input   logic           i_ack_en,       // acknowledge a written byte
        input   logic   [7:0]   i_rd_byte,
        output  logic           o_sda_drive_low,
        output  logic           o_seen_start,
        output  logic           o_seen_stop,
        output  logic   [7:0]   o_wr_byte,
        output  logic           o_master_ack
);

        logic           scl_q;
        logic           sda_q;
        logic   [3:0]   bit_cnt;        // rising scl edges since start or clear

        // oversampled on the system clock so edges show one cycle late
        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                begin
                        scl_q           <= 1'b1;
                        sda_q           <= 1'b1;
                        bit_cnt         <= 4'd0;
                        o_sda_drive_low <= 1'b0;
                        o_seen_start    <= 1'b0;
                        o_seen_stop     <= 1'b0;
                        o_wr_byte       <= 8'h00;
                        o_master_ack    <= 1'b0;
                end
                else
                begin
                        scl_q <= i_scl;
                        sda_q <= i_sda;
                        if (i_clear)
                        begin
                                bit_cnt         <= 4'd0;
                                o_sda_drive_low <= 1'b0;
                                o_seen_start    <= 1'b0;
                                o_seen_stop     <= 1'b0;
                                o_wr_byte       <= 8'h00;
                                o_master_ack    <= 1'b0;
                        end
                        else if (scl_q && i_scl && sda_q && !i_sda)
                        begin
                                o_seen_start <= 1'b1;
                                bit_cnt      <= 4'd0;
                        end
                        else if (scl_q && i_scl && !sda_q && i_sda)
                                o_seen_stop <= 1'b1;
                        else if (!scl_q && i_scl)
                        begin
                                if (bit_cnt < 4'd8)
                                        o_wr_byte <= {o_wr_byte[6:0], i_sda};
                                else if ((bit_cnt == 4'd8) && i_read)
                                        o_master_ack <= i_sda;  // high is nack
                                if (bit_cnt != 4'd15)
                                        bit_cnt <= bit_cnt + 4'd1;
                        end
                        else if (scl_q && !i_scl)
                        begin
                                if (i_read && (bit_cnt < 4'd8))
                                        o_sda_drive_low <= !i_rd_byte[3'd7 - bit_cnt[2:0]];
                                else if (!i_read && (bit_cnt == 4'd8))
                                        o_sda_drive_low <= i_ack_en;
                                else
                                        o_sda_drive_low <= 1'b0;
                        end
                end
        end

endmodule

/* verification/tb_i2c_word_master.sv */
`timescale 1ns/1ns

module tb_i2c_word_master;

        // one transfer and what it should leave behind
        typedef struct packed
        {
                logic   [i2c_pkg::c_cmd_w-1:0]  cmd;
                logic   [7:0]                   tx;
                logic   [7:0]                   rd_byte;
                logic                           slave_ack;
                logic                           want_done;
                logic                           exp_ack;
                logic   [7:0]                   exp_rx;
                logic   [7:0]                   exp_cap;
                logic                           exp_mack;
                logic                           exp_start;
                logic                           exp_stop;
        } row_t;

        logic                           i_sysclk;
        logic                           i_sysrst_n;
        logic   [i2c_pkg::c_cmd_w-1:0]  i_cmd;
        logic   [i2c_pkg::c_data_w-1:0] i_tx_data;
        logic                           i_iic_start;
        logic                           o_iic_scl;
        logic                           o_sda_drive_low;
        logic                           o_ack;
        logic   [i2c_pkg::c_data_w-1:0] o_rx_data;
        logic                           o_iic_done;
        logic                           sda_line;
        logic                           slave_drive_low;
        logic                           slave_clear;
        logic                           slave_read;
        logic                           slave_ack_en;
        logic   [7:0]                   slave_rd_byte;
        logic                           seen_start;
        logic                           seen_stop;
        logic   [7:0]                   slave_wr_byte;
        logic                           slave_master_ack;
        row_t                           rows [0:8];
        integer                         errors;
        integer                         checks;
        integer                         seed;
        string                          stage;

        assign sda_line = !(o_sda_drive_low | slave_drive_low);        // pull-up

        i2c_word_master dut
        (
                .i_sysclk               (i_sysclk),
                .i_sysrst_n             (i_sysrst_n),
                .i_cmd                  (i_cmd),
                .i_tx_data              (i_tx_data),
                .i_iic_start            (i_iic_start),
                .i_sda                  (sda_line),
                .o_iic_scl              (o_iic_scl),
                .o_sda_drive_low        (o_sda_drive_low),
                .o_ack                  (o_ack),
                .o_rx_data              (o_rx_data),
                .o_iic_done             (o_iic_done)
        );

        i2c_slave_model u_slave
        (
                .i_sysclk               (i_sysclk),
                .i_sysrst_n             (i_sysrst_n),
                .i_clear                (slave_clear),
                .i_scl                  (o_iic_scl),
                .i_sda                  (sda_line),
                .i_read                 (slave_read),
                .i_ack_en               (slave_ack_en),
                .i_rd_byte              (slave_rd_byte),
                .o_sda_drive_low        (slave_drive_low),
                .o_seen_start           (seen_start),
                .o_seen_stop            (seen_stop),
                .o_wr_byte              (slave_wr_byte),
                .o_master_ack           (slave_master_ack)
        );

        always #50 i_sysclk = ~i_sysclk;

        function automatic logic [i2c_pkg::c_cmd_w-1:0] flag(input i2c_pkg::cmd_bit_e b);
                flag = 6'd1 << b;
        endfunction

        task automatic compare_value(input string name, input logic [31:0] got,
                                     input logic [31:0] want);
                checks = checks + 1;
                if (got !== want)
                begin
                        $display("MISMATCH %s (%s): got 0x%0h, expected 0x%0h",
                                 name, stage, got, want);
                        errors = errors + 1;
                end
        endtask

        task automatic load_table();
                logic   [i2c_pkg::c_cmd_w-1:0]  wr_stop;
                logic   [i2c_pkg::c_cmd_w-1:0]  rd_ack;
                logic   [i2c_pkg::c_cmd_w-1:0]  rd_nack;
                logic   [7:0]                   rnd_tx;
                logic   [7:0]                   rnd_rd;
                wr_stop = flag(i2c_pkg::cmd_sta) | flag(i2c_pkg::cmd_wr) | flag(i2c_pkg::cmd_sto);
                rd_ack  = flag(i2c_pkg::cmd_sta) | flag(i2c_pkg::cmd_rd) | flag(i2c_pkg::cmd_sto) |
                          flag(i2c_pkg::cmd_ack);
                rd_nack = flag(i2c_pkg::cmd_sta) | flag(i2c_pkg::cmd_rd) | flag(i2c_pkg::cmd_sto) |
                          flag(i2c_pkg::cmd_nack);
                rnd_tx  = 8'($random(seed));
                rnd_rd  = 8'($random(seed));
                // cmd, tx, rd_byte, slave_ack, want_done, ack, rx, cap, mack, start, stop
                rows[0] = '{wr_stop, 8'hA5, 8'h00, 1'b1, 1'b1, 1'b0, 8'h00, 8'hA5, 1'b0, 1'b1, 1'b1};
                rows[1] = '{wr_stop, 8'h3C, 8'h00, 1'b0, 1'b1, 1'b1, 8'h00, 8'h3C, 1'b0, 1'b1, 1'b1};
                rows[2] = '{rd_ack, 8'h00, 8'hC3, 1'b1, 1'b1, 1'b1, 8'hC3, 8'hC3, 1'b0, 1'b1, 1'b1};
                rows[3] = '{rd_nack, 8'h00, 8'h5A, 1'b1, 1'b1, 1'b1, 8'h5A, 8'h5A, 1'b1, 1'b1, 1'b1};
                // no stop here so the next row continues on a held bus
                rows[4] = '{flag(i2c_pkg::cmd_sta) | flag(i2c_pkg::cmd_wr), 8'h96, 8'h00, 1'b1,
                            1'b1, 1'b0, 8'h5A, 8'h96, 1'b0, 1'b1, 1'b0};
                rows[5] = '{flag(i2c_pkg::cmd_wr), 8'h69, 8'h00, 1'b1,
                            1'b1, 1'b0, 8'h5A, 8'h69, 1'b0, 1'b0, 1'b0};
                rows[6] = '{flag(i2c_pkg::cmd_sto), 8'hFF, 8'h00, 1'b1,
                            1'b0, 1'b0, 8'h5A, 8'h00, 1'b0, 1'b0, 1'b0};
                rows[7] = '{wr_stop, rnd_tx, 8'h00, 1'b1,
                            1'b1, 1'b0, 8'h5A, rnd_tx, 1'b0, 1'b1, 1'b1};
                rows[8] = '{rd_ack, 8'h00, rnd_rd, 1'b1,
                            1'b1, 1'b0, rnd_rd, rnd_rd, 1'b0, 1'b1, 1'b1};
        endtask

        task automatic wait_for_done(input logic want_done);
                integer cycles;
                logic   scl_before;
                logic   moved;
                logic   seen;
                scl_before = o_iic_scl;
                cycles     = 0;
                moved      = 1'b0;
                seen       = 1'b0;
                while (!seen && (cycles < 8000))
                begin
                        @(negedge i_sysclk);
                        cycles = cycles + 1;
                        if (o_iic_done)
                                seen = 1'b1;
                        if ((o_iic_scl !== scl_before) || o_sda_drive_low)
                                moved = 1'b1;
                end
                if (want_done && !seen)
                begin
                        $display("%s: timed out, no o_iic_done within 8000 cycles", stage);
                        errors = errors + 1;
                end
                if (!want_done && seen)
                begin
                        $display("%s: o_iic_done pulsed for a command that must be ignored", stage);
                        errors = errors + 1;
                end
                if (!want_done && moved)
                begin
                        $display("%s: bus lines moved for a command that must be ignored", stage);
                        errors = errors + 1;
                end
        endtask

        task automatic run_row(input integer n);
                row_t   r;
                r     = rows[n];
                stage = $sformatf("row %0d", n);
                @(posedge i_sysclk);
                slave_clear   <= 1'b1;
                slave_read    <= r.cmd[i2c_pkg::cmd_rd];
                slave_ack_en  <= r.slave_ack;
                slave_rd_byte <= r.rd_byte;
                @(posedge i_sysclk);
                slave_clear <= 1'b0;
                i_cmd       <= r.cmd;
                i_tx_data   <= r.tx;
                i_iic_start <= 1'b1;
                @(posedge i_sysclk);
                i_iic_start <= 1'b0;
                i_cmd       <= '0;      // dut works from its latched copy
                i_tx_data   <= '0;
                wait_for_done(r.want_done);
                compare_value("o_ack", 32'(o_ack), 32'(r.exp_ack));
                compare_value("o_rx_data", 32'(o_rx_data), 32'(r.exp_rx));
                compare_value("slave byte", 32'(slave_wr_byte), 32'(r.exp_cap));
                compare_value("seen_start", 32'(seen_start), 32'(r.exp_start));
                compare_value("seen_stop", 32'(seen_stop), 32'(r.exp_stop));
                if (r.cmd[i2c_pkg::cmd_rd])
                        compare_value("master ack", 32'(slave_master_ack), 32'(r.exp_mack));
                if (r.want_done && r.cmd[i2c_pkg::cmd_sto])
                begin
                        compare_value("o_iic_scl", 32'(o_iic_scl), 32'd1);     // idle bus
                        compare_value("o_sda_drive_low", 32'(o_sda_drive_low), 32'd0);
                end
        endtask

        initial
        begin
                i_sysclk      = 1'b0;
                i_sysrst_n    = 1'b0;
                i_cmd         = '0;
                i_tx_data     = '0;
                i_iic_start   = 1'b0;
                slave_clear   = 1'b0;
                slave_read    = 1'b0;
                slave_ack_en  = 1'b1;
                slave_rd_byte = 8'h00;
                errors        = 0;
                checks        = 0;
                seed          = 32'h8c82_5327;
                stage         = "reset";
                load_table();
                repeat (3) @(posedge i_sysclk);
                i_sysrst_n <= 1'b1;
                @(negedge i_sysclk);
                compare_value("o_iic_scl", 32'(o_iic_scl), 32'd1);
                compare_value("o_sda_drive_low", 32'(o_sda_drive_low), 32'd0);
                compare_value("o_iic_done", 32'(o_iic_done), 32'd0);
                compare_value("o_ack", 32'(o_ack), 32'd0);
                compare_value("o_rx_data", 32'(o_rx_data), 32'd0);
                for (int i = 0; i < 9; i++)
                        run_row(i);
                $display("summary: %0d checks, %0d errors", checks, errors);
                if (errors == 0)
                        $display("*** PASSED ***");
                else
                        $display("*** FAILED ***");
                $finish;
        end

endmodule

/* files.f */
hw/i2c_pkg.sv
hw/i2c_phase_if.sv
hw/i2c_bit_engine.sv
hw/i2c_cmd_fsm.sv
hw/i2c_word_master.sv
verification/i2c_slave_model.sv
verification/tb_i2c_word_master.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_i2c_word_master
FILELIST = files.f
OBJ_DIR  = obj_dir
PASS_MSG = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
